/* Bender.yml */
package:
  name: aes_engine

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/aes_pkg.sv
      - hdl/aes_input_stage.sv
      - hdl/aes_round_core.sv
      - hdl/aes_mode_unit.sv
      - hdl/aes_output_stage.sv
      - hdl/aes_controller.sv
  - target: simulation
    files:
      - dv/aes_tb.sv

/* dv/aes_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module aes_tb;

	import aes_pkg::*;

	// About 40 blocks at well under 100 cycles each, with ample margin
	localparam int TIMEOUT_CYCLES = 20000;

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic        in_wren = 1'b0;
	logic        in_last = 1'b0;
	logic [31:0] in_data = 32'h0;
	logic        out_ready = 1'b0;
	logic        in_busy;
	logic        out_valid;
	logic [31:0] out_data;
	logic        out_last;

	logic [31:0]  exp_data [$];
	logic         exp_last [$];
	logic [31:0]  got_data [$];
	logic [127:0] msg_blk [16];
	logic [127:0] plain [16];
	bit           ready_random = 1'b0;
	int           errors = 0;
	int           checked = 0;
	int           cycles = 0;

	aes_controller UUT (
		.clk(clk),
		.reset(reset),
		.in_wren(in_wren),
		.in_last(in_last),
		.in_data(in_data),
		.in_busy(in_busy),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data),
		.out_last(out_last)
	);

	always #10 clk = ~clk;

	// ==========================================================================
	// Reference model

	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic logic [127:0] aes_ref(input logic [127:0] key, input logic [127:0] pt);
		logic [7:0]   s [16];
		logic [7:0]   t [16];
		logic [127:0] rk;
		logic [127:0] ct;
		logic [31:0]  w;
		logic [7:0]   rc;
		logic [7:0]   a0, a1, a2, a3;
		rk = key;
		rc = 8'h01;
		for (int k = 0; k < 16; k++)
			s[k] = pt[127 - 8 * k -: 8] ^ key[127 - 8 * k -: 8];
		for (int rnd = 1; rnd <= 10; rnd++) begin
			// RotWord, SubWord, Rcon
			w = {aes_sbox(rk[23:16]), aes_sbox(rk[15:8]), aes_sbox(rk[7:0]),
				aes_sbox(rk[31:24])};
			w[31:24] = w[31:24] ^ rc;
			rk[127:96] = rk[127:96] ^ w;
			rk[95:64] = rk[95:64] ^ rk[127:96];
			rk[63:32] = rk[63:32] ^ rk[95:64];
			rk[31:0] = rk[31:0] ^ rk[63:32];
			rc = xtime(rc);
			// SubBytes with ShiftRows, row r rotated left by r
			for (int col = 0; col < 4; col++)
				for (int row = 0; row < 4; row++)
					t[4 * col + row] = aes_sbox(s[4 * ((col + row) % 4) + row]);
			for (int col = 0; col < 4; col++) begin
				a0 = t[4 * col];
				a1 = t[4 * col + 1];
				a2 = t[4 * col + 2];
				a3 = t[4 * col + 3];
				if (rnd < 10) begin
					s[4 * col] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
					s[4 * col + 1] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
					s[4 * col + 2] = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
					s[4 * col + 3] = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
				end else begin
					s[4 * col] = a0;
					s[4 * col + 1] = a1;
					s[4 * col + 2] = a2;
					s[4 * col + 3] = a3;
				end
			end
			for (int k = 0; k < 16; k++)
				s[k] = s[k] ^ rk[127 - 8 * k -: 8];
		end
		for (int k = 0; k < 16; k++)
			ct[127 - 8 * k -: 8] = s[k];
		return ct;
	endfunction

	function automatic logic [127:0] mode_ref(input aes_mode_e mode, input logic dec,
		input logic [127:0] key, input logic [127:0] data, input logic [127:0] iv,
		output logic [127:0] iv_next);
		logic [127:0] ks;
		logic [127:0] res;
		iv_next = iv;
		case (mode)
			MODE_ECB: res = aes_ref(key, data);
			MODE_CBC: begin
				res = aes_ref(key, data ^ iv);
				iv_next = res;
			end
			MODE_CTR: begin
				res = data ^ aes_ref(key, iv);
				iv_next = iv + 128'd1;
			end
			MODE_CFB: begin
				res = data ^ aes_ref(key, iv);
				iv_next = dec ? data : res;
			end
			default: begin
				ks = aes_ref(key, iv);
				res = data ^ ks;
				iv_next = ks;
			end
		endcase
		return res;
	endfunction

	function automatic logic [127:0] rand_blk();
		return {$urandom(), $urandom(), $urandom(), $urandom()};
	endfunction

	function automatic logic [127:0] got_block(input int i);
		return {got_data[4 * i], got_data[4 * i + 1], got_data[4 * i + 2], got_data[4 * i + 3]};
	endfunction

	// ==========================================================================
	// Stimulus

	// Called and returns at 1 ns after a rising edge
	task automatic send_word(input logic [31:0] w, input logic last, input bit gaps);
		if (gaps) begin
			while ($urandom_range(0, 3) == 0) begin
				@(posedge clk);
				#1;
			end
		end
		while (in_busy) begin
			@(posedge clk);
			#1;
		end
		in_wren = 1'b1;
		in_data = w;
		in_last = last;
		@(posedge clk);
		#1;
		in_wren = 1'b0;
		in_last = 1'b0;
	endtask

	task automatic send_block(input logic [127:0] blk, input logic last, input bit gaps);
		for (int w = 0; w < 4; w++)
			send_word(blk[127 - 32 * w -: 32], last && (w == 3), gaps);
	endtask

	task automatic send_message(input aes_mode_e mode, input logic dec, input logic [127:0] key,
		input logic [127:0] iv, input int nblk, input bit gaps);
		logic [127:0] chain;
		logic [127:0] res;
		chain = iv;
		send_block({124'h0, dec, mode}, 1'b0, gaps);
		send_block(key, 1'b0, gaps);
		if (mode != MODE_ECB)
			send_block(iv, 1'b0, gaps);
		for (int i = 0; i < nblk; i++) begin
			res = mode_ref(mode, dec, key, msg_blk[i], chain, chain);
			for (int w = 0; w < 4; w++) begin
				exp_data.push_back(res[127 - 32 * w -: 32]);
				exp_last.push_back((i == nblk - 1) && (w == 3));
			end
			send_block(msg_blk[i], i == nblk - 1, gaps);
		end
	endtask

	task automatic wait_drain();
		while (exp_data.size() != 0)
			@(posedge clk);
		#1;
	endtask

	always @(posedge clk) begin
		#1;
		out_ready = ready_random ? 1'($urandom_range(0, 1)) : 1'b1;
	end

	// ==========================================================================
	// Checking

	// Values are stable at the falling edge; the transfer happens at the next rise
	always @(negedge clk) begin
		logic [31:0] ed;
		logic        el;
		if (!reset && out_valid && out_ready) begin
			if (exp_data.size() == 0) begin
				$display("Output word %h arrived with no result expected", out_data);
				errors++;
			end else begin
				ed = exp_data.pop_front();
				el = exp_last.pop_front();
				checked++;
				if (out_data !== ed) begin
					$display("FAILED out_data: got %h expected %h", out_data, ed);
					errors++;
				end
				if (out_last !== el) begin
					$display("FAILED out_last: got %h expected %h", out_last, el);
					errors++;
				end
				got_data.push_back(out_data);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles with %0d words still expected",
				cycles, exp_data.size());
			$display("Errors: %0d, words checked: %0d", errors + 1, checked);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		logic [127:0] key;
		logic [127:0] iv;
		int           wait_cycles;
		void'($urandom(32'h9ce934fd));
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		if (in_busy !== 1'b0 || out_valid !== 1'b0) begin
			$display("Busy or output valid is high right after reset");
			errors++;
		end

		// FIPS-197 known answer
		key = 128'h000102030405060708090a0b0c0d0e0f;
		msg_blk[0] = 128'h00112233445566778899aabbccddeeff;
		if (aes_ref(key, msg_blk[0]) !== 128'h69c4e0d86a7b0430d8cdb78070b4c55a) begin
			$display("Reference AES does not reproduce the FIPS-197 vector");
			errors++;
		end
		send_message(MODE_ECB, 1'b0, key, 128'h0, 1, 1'b0);
		wait_drain();
		if (got_block(0) !== 128'h69c4e0d86a7b0430d8cdb78070b4c55a) begin
			$display("FAILED ecb_vector: got %h expected %h", got_block(0),
				128'h69c4e0d86a7b0430d8cdb78070b4c55a);
			errors++;
		end

		// CBC chaining
		for (int i = 0; i < 5; i++)
			msg_blk[i] = rand_blk();
		send_message(MODE_CBC, 1'b0, rand_blk(), rand_blk(), 5, 1'b0);

		// Counter carry across the low 64 bits
		for (int i = 0; i < 4; i++)
			msg_blk[i] = rand_blk();
		iv = rand_blk();
		iv[63:0] = 64'hffff_ffff_ffff_ffff;
		send_message(MODE_CTR, 1'b0, rand_blk(), iv, 4, 1'b0);
		wait_drain();

		// CFB round trip through the DUT's own ciphertext
		key = rand_blk();
		iv = rand_blk();
		for (int i = 0; i < 3; i++) begin
			plain[i] = rand_blk();
			msg_blk[i] = plain[i];
		end
		got_data.delete();
		send_message(MODE_CFB, 1'b0, key, iv, 3, 1'b0);
		wait_drain();
		for (int i = 0; i < 3; i++)
			msg_blk[i] = got_block(i);
		got_data.delete();
		send_message(MODE_CFB, 1'b1, key, iv, 3, 1'b0);
		wait_drain();
		for (int i = 0; i < 3; i++) begin
			if (got_block(i) !== plain[i]) begin
				$display("FAILED cfb_roundtrip: got %h expected %h", got_block(i), plain[i]);
				errors++;
			end
		end

		for (int i = 0; i < 3; i++)
			msg_blk[i] = rand_blk();
		send_message(MODE_OFB, 1'b0, rand_blk(), rand_blk(), 3, 1'b0);
		wait_drain();

		// Back-pressure on both sides
		ready_random = 1'b1;
		for (int i = 0; i < 12; i++)
			msg_blk[i] = rand_blk();
		send_message(MODE_OFB, 1'b0, rand_blk(), rand_blk(), 12, 1'b1);
		wait_drain();
		ready_random = 1'b0;

		// Back-to-back messages, chaining state fresh each time
		key = rand_blk();
		iv = rand_blk();
		for (int i = 0; i < 2; i++)
			msg_blk[i] = rand_blk();
		send_message(MODE_ECB, 1'b0, key, iv, 2, 1'b0);
		send_message(MODE_CTR, 1'b0, key, iv, 2, 1'b0);
		send_message(MODE_CBC, 1'b0, key, iv, 2, 1'b0);

		wait_cycles = 0;
		while (exp_data.size() != 0 && wait_cycles < 2000) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (exp_data.size() != 0) begin
			$display("%0d expected output words never appeared", exp_data.size());
			errors++;
		end
		// Catch any extra words
		repeat (20) @(posedge clk);

		$display("Errors: %0d, words checked: %0d", errors, checked);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/aes_controller.sv */
`timescale 1ns/10ps
`default_nettype none

`include "aes_params.svh"

module aes_controller (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      in_wren,
	input  wire                      in_last,
	input  wire [`AES_BUS_BITS-1:0]  in_data,
	output logic                     in_busy,
	output logic                     out_valid,
	input  wire                      out_ready,
	output logic [`AES_BUS_BITS-1:0] out_data,
	output logic                     out_last
);

	import aes_pkg::*;

	localparam logic [2:0] S_CMD = 3'd0;
	localparam logic [2:0] S_KEY = 3'd1;
	localparam logic [2:0] S_IV = 3'd2;
	localparam logic [2:0] S_PROC = 3'd3;
	localparam logic [2:0] S_DATA = 3'd4;

	logic                     blk_valid;
	logic                     blk_ready;
	logic [`AES_BLK_BITS:0]   blk;
	logic                     blk_take;
	aes_word_u                fifo_word;

	logic [2:0]               state;
	aes_word_u                cmd;
	logic [`AES_BLK_BITS-1:0] key;
	logic [`AES_BLK_BITS-1:0] iv;
	logic [`AES_BLK_BITS-1:0] data_blk;
	logic                     last_blk;

	logic                     start;
	logic                     done;
	logic [`AES_BLK_BITS-1:0] core_in;
	logic [`AES_BLK_BITS-1:0] core_out;
	logic [`AES_BLK_BITS-1:0] res_blk;
	logic [`AES_BLK_BITS-1:0] iv_next;

	logic                     res_valid;
	logic                     res_ready;
	logic [`AES_BLK_BITS:0]   res;

	// ==========================================================================
	// Input side

	aes_input_stage u_input (
		.clk(clk),
		.reset(reset),
		.wren(in_wren),
		.tlast(in_last),
		.data(in_data),
		.blk_ready(blk_ready),
		.busy(in_busy),
		.blk_valid(blk_valid),
		.blk(blk)
	);

	assign fifo_word = blk[`AES_BLK_BITS-1:0];
	assign blk_take = blk_valid && blk_ready;

	// ==========================================================================
	// Message FSM

	// Data blocks wait for an idle core and an empty result register
	always_comb begin
		case (state)
			S_CMD, S_KEY, S_IV: blk_ready = 1'b1;
			S_DATA:             blk_ready = !start && !res_valid;
			default:            blk_ready = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_CMD;
			cmd <= '0;
			last_blk <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				S_CMD: begin
					if (blk_take) begin
						cmd <= fifo_word;
						state <= S_KEY;
					end
				end
				S_KEY: begin
					if (blk_take)
						state <= (cmd.cmd.mode == MODE_ECB) ? S_DATA : S_IV;
				end
				S_IV: begin
					if (blk_take)
						state <= S_DATA;
				end
				S_DATA: begin
					if (blk_take) begin
						last_blk <= blk[`AES_BLK_BITS];
						start <= 1'b1;
						state <= S_PROC;
					end
				end
				S_PROC: begin
					if (done)
						state <= last_blk ? S_CMD : S_DATA;
				end
				default: state <= S_CMD;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (blk_take && state == S_KEY)
			key <= fifo_word.raw;
		if (blk_take && state == S_DATA)
			data_blk <= fifo_word.raw;
		if (blk_take && state == S_IV)
			iv <= fifo_word.raw;
		else if (done)
			iv <= iv_next;
		if (done)
			res <= {last_blk, res_blk};
	end

	// ==========================================================================
	// Chaining and cipher

	aes_mode_unit u_mode (
		.mode(cmd.cmd.mode),
		.decrypt(cmd.cmd.decrypt),
		.data_blk(data_blk),
		.iv(iv),
		.core_out(core_out),
		.core_in(core_in),
		.res_blk(res_blk),
		.iv_next(iv_next)
	);

	aes_round_core u_core (
		.clk(clk),
		.reset(reset),
		.start(start),
		.key(key),
		.in_blk(core_in),
		.out_blk(core_out),
		.done(done)
	);

	// ==========================================================================
	// Output side

	always_ff @(posedge clk) begin
		if (reset)
			res_valid <= 1'b0;
		else if (done)
			res_valid <= 1'b1;
		else if (res_ready)
			res_valid <= 1'b0;
	end

	aes_output_stage u_output (
		.clk(clk),
		.reset(reset),
		.res_valid(res_valid),
		.res(res),
		.out_ready(out_ready),
		.res_ready(res_ready),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_last(out_last)
	);

endmodule

`default_nettype wire

/* hdl/aes_input_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "aes_params.svh"

module aes_input_stage (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      wren,
	input  wire                      tlast,
	input  wire [`AES_BUS_BITS-1:0]  data,
	input  wire                      blk_ready,
	output logic                     busy,
	output logic                     blk_valid,
	output logic [`AES_BLK_BITS:0]   blk
);

	localparam int DEPTH = `AES_IN_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int IDX_W = $clog2(`AES_WORDS_PER_BLK);
	localparam int SH_W = `AES_BLK_BITS - `AES_BUS_BITS;
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`AES_WORDS_PER_BLK - 1);

	logic [IDX_W-1:0]        word_idx;
	logic [SH_W-1:0]         shreg;
	logic [`AES_BLK_BITS:0]  mem [DEPTH];
	logic [PTR_W-1:0]        wr_ptr;
	logic [PTR_W-1:0]        rd_ptr;
	logic [CNT_W-1:0]        count;
	logic                    push;
	logic                    pop;

	// Last word of a block completes an entry
	assign push = wren && (word_idx == LAST_IDX);
	assign pop = blk_valid && blk_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			word_idx <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wren)
				word_idx <= (word_idx == LAST_IDX) ? '0 : word_idx + 1'b1;
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// First word ends up in the top bits
	always_ff @(posedge clk) begin
		if (wren)
			shreg <= {shreg[SH_W-`AES_BUS_BITS-1:0], data};
		if (push)
			mem[wr_ptr] <= {tlast, shreg, data};
	end

	assign busy = (count == CNT_W'(DEPTH));
	assign blk_valid = (count != '0);
	assign blk = mem[rd_ptr];

endmodule

`default_nettype wire

/* hdl/aes_mode_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "aes_params.svh"

module aes_mode_unit (
	input  var aes_pkg::aes_mode_e   mode,
	input  wire                      decrypt,
	input  wire [`AES_BLK_BITS-1:0]  data_blk,
	input  wire [`AES_BLK_BITS-1:0]  iv,
	input  wire [`AES_BLK_BITS-1:0]  core_out,
	output logic [`AES_BLK_BITS-1:0] core_in,
	output logic [`AES_BLK_BITS-1:0] res_blk,
	output logic [`AES_BLK_BITS-1:0] iv_next
);

	import aes_pkg::*;

	always_comb begin
		// Stream modes encrypt the IV and mask the data
		core_in = iv;
		res_blk = data_blk ^ core_out;
		iv_next = iv;
		case (mode)
			MODE_ECB: begin
				core_in = data_blk;
				res_blk = core_out;
			end
			MODE_CBC: begin
				core_in = data_blk ^ iv;
				res_blk = core_out;
				iv_next = core_out;
			end
			MODE_CTR: begin
				iv_next = iv + 1'b1;
			end
			MODE_CFB: begin
				// Ciphertext feeds back in both directions
				iv_next = decrypt ? data_blk : data_blk ^ core_out;
			end
			MODE_OFB: begin
				iv_next = core_out;
			end
			default: begin
				core_in = data_blk;
				res_blk = core_out;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/aes_output_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "aes_params.svh"

module aes_output_stage (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      res_valid,
	input  wire [`AES_BLK_BITS:0]    res,
	input  wire                      out_ready,
	output logic                     res_ready,
	output logic                     out_valid,
	output logic [`AES_BUS_BITS-1:0] out_data,
	output logic                     out_last
);

	localparam int DEPTH = `AES_OUT_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int IDX_W = $clog2(`AES_WORDS_PER_BLK);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`AES_WORDS_PER_BLK - 1);

	logic [`AES_BLK_BITS:0]  mem [DEPTH];
	logic [`AES_BLK_BITS:0]  head;
	logic [PTR_W-1:0]        wr_ptr;
	logic [PTR_W-1:0]        rd_ptr;
	logic [CNT_W-1:0]        count;
	logic [IDX_W-1:0]        word_idx;
	logic                    push;
	logic                    pop;
	logic                    word_xfer;

	assign res_ready = (count != CNT_W'(DEPTH));
	assign push = res_valid && res_ready;
	assign word_xfer = out_valid && out_ready;
	// Entry leaves after its last word
	assign pop = word_xfer && (word_idx == LAST_IDX);

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			word_idx <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (word_xfer)
				word_idx <= (word_idx == LAST_IDX) ? '0 : word_idx + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= res;
	end

	// Most significant word goes out first
	assign head = mem[rd_ptr];
	assign out_valid = (count != '0);
	assign out_data = head[`AES_BLK_BITS-1 - `AES_BUS_BITS * word_idx -: `AES_BUS_BITS];
	assign out_last = head[`AES_BLK_BITS] && (word_idx == LAST_IDX);

endmodule

`default_nettype wire

/* hdl/aes_params.svh */
`ifndef AES_PARAMS_SVH
`define AES_PARAMS_SVH

// Block, key and IV width
`define AES_BLK_BITS 128

// Both bus data paths
`define AES_BUS_BITS 32
`define AES_WORDS_PER_BLK 4

// FIFO entry counts
`define AES_IN_FIFO_DEPTH 4
`define AES_OUT_FIFO_DEPTH 4

// AES-128 round count, one round per cycle
`define AES_ROUNDS 10

`endif

/* hdl/aes_pkg.sv */
`default_nettype none

`include "aes_params.svh"

package aes_pkg;

	typedef enum logic [2:0] {
		MODE_ECB = 3'd0,
		MODE_CBC = 3'd1,
		MODE_CTR = 3'd2,
		MODE_CFB = 3'd3,
		MODE_OFB = 3'd4
	} aes_mode_e;

	// One FIFO word, either a raw block or a command
	typedef union packed {
		logic [`AES_BLK_BITS-1:0] raw;
		struct packed {
			logic [`AES_BLK_BITS-5:0] reserved;
			logic                     decrypt;
			aes_mode_e                mode;
		} cmd;
	} aes_word_u;

	// GF(2^8) multiply, AES polynomial
	function automatic logic [7:0] aes_gmul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		logic [7:0] x;
		p = 8'h00;
		x = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				p = p ^ x;
			x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
		end
		return p;
	endfunction

	// Forward S-box from the field inverse and the affine map
	function automatic logic [7:0] aes_sbox(input logic [7:0] b);
		logic [7:0] sq;
		logic [7:0] inv;
		logic [7:0] s;
		sq = b;
		inv = 8'h01;
		// b^254 = b^2 * b^4 * ... * b^128, zero maps to zero
		for (int i = 0; i < 7; i++) begin
			sq = aes_gmul(sq, sq);
			inv = aes_gmul(inv, sq);
		end
		for (int i = 0; i < 8; i++) begin
			s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^
				inv[(i + 6) % 8] ^ inv[(i + 7) % 8];
		end
		return s ^ 8'h63;
	endfunction

endpackage

`default_nettype wire

/* hdl/aes_round_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "aes_params.svh"

module aes_round_core (
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      start,
	input  wire [`AES_BLK_BITS-1:0]  key,
	input  wire [`AES_BLK_BITS-1:0]  in_blk,
	output logic [`AES_BLK_BITS-1:0] out_blk,
	output logic                     done
);

	import aes_pkg::*;

	localparam int RND_W = $clog2(`AES_ROUNDS + 1);

	logic [`AES_BLK_BITS-1:0] st;
	logic [`AES_BLK_BITS-1:0] st_next;
	logic [`AES_BLK_BITS-1:0] rk;
	logic [`AES_BLK_BITS-1:0] rk_next;
	logic [7:0]               rcon;
	logic [RND_W-1:0]         rnd;
	logic                     busy;
	logic                     last_round;
	logic                     load;

	assign load = start && !busy;
	assign last_round = (rnd == RND_W'(`AES_ROUNDS));

	// Next round key from the current one
	always_comb begin
		logic [31:0] temp;
		temp = {aes_sbox(rk[23:16]), aes_sbox(rk[15:8]), aes_sbox(rk[7:0]),
			aes_sbox(rk[31:24])};
		temp[31:24] = temp[31:24] ^ rcon;
		rk_next[127:96] = rk[127:96] ^ temp;
		rk_next[95:64] = rk[95:64] ^ rk_next[127:96];
		rk_next[63:32] = rk[63:32] ^ rk_next[95:64];
		rk_next[31:0] = rk[31:0] ^ rk_next[63:32];
	end

	// One full round; byte k sits at row k%4, column k/4
	always_comb begin
		logic [7:0] sb [16];
		logic [7:0] sr [16];
		logic [7:0] mc [16];
		for (int k = 0; k < 16; k++)
			sb[k] = aes_sbox(st[127 - 8 * k -: 8]);
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++)
				sr[4 * c + r] = sb[4 * ((c + r) % 4) + r];
		end
		for (int c = 0; c < 4; c++) begin
			mc[4 * c] = aes_gmul(sr[4 * c], 8'h02) ^ aes_gmul(sr[4 * c + 1], 8'h03) ^
				sr[4 * c + 2] ^ sr[4 * c + 3];
			mc[4 * c + 1] = sr[4 * c] ^ aes_gmul(sr[4 * c + 1], 8'h02) ^
				aes_gmul(sr[4 * c + 2], 8'h03) ^ sr[4 * c + 3];
			mc[4 * c + 2] = sr[4 * c] ^ sr[4 * c + 1] ^
				aes_gmul(sr[4 * c + 2], 8'h02) ^ aes_gmul(sr[4 * c + 3], 8'h03);
			mc[4 * c + 3] = aes_gmul(sr[4 * c], 8'h03) ^ sr[4 * c + 1] ^
				sr[4 * c + 2] ^ aes_gmul(sr[4 * c + 3], 8'h02);
		end
		// No MixColumns in the final round
		for (int k = 0; k < 16; k++)
			st_next[127 - 8 * k -: 8] = (last_round ? sr[k] : mc[k]) ^ rk_next[127 - 8 * k -: 8];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			rnd <= '0;
		end else begin
			done <= 1'b0;
			if (load) begin
				busy <= 1'b1;
				rnd <= RND_W'(1);
			end else if (busy) begin
				rnd <= rnd + 1'b1;
				if (last_round) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// Initial AddRoundKey on load
	always_ff @(posedge clk) begin
		if (load) begin
			st <= in_blk ^ key;
			rk <= key;
			rcon <= 8'h01;
		end else if (busy) begin
			st <= st_next;
			rk <= rk_next;
			rcon <= aes_gmul(rcon, 8'h02);
		end
	end

	assign out_blk = st;

endmodule

`default_nettype wire

/* sources.f */
+incdir+hdl
hdl/aes_pkg.sv
hdl/aes_input_stage.sv
hdl/aes_round_core.sv
hdl/aes_mode_unit.sv
hdl/aes_output_stage.sv
hdl/aes_controller.sv
dv/aes_tb.sv
